// File: source/scc_consts.svh
`ifndef SCC_CONSTS_SVH
`define SCC_CONSTS_SVH

// write register indices behind the wr0 pointer
`define SCC_REG_WR0 4'd0
`define SCC_REG_WR1 4'd1
`define SCC_REG_WR2 4'd2
`define SCC_REG_WR3 4'd3
`define SCC_REG_WR5 4'd5
`define SCC_REG_WR9 4'd9
`define SCC_REG_WR12 4'd12
`define SCC_REG_WR13 4'd13
`define SCC_REG_WR14 4'd14
`define SCC_REG_WR15 4'd15

`define SCC_RST_WR15 8'hF8 // all ext/status enables except zero count

// wr0 command field, bits 5:3
`define SCC_CMD_POINT_HIGH 3'd1
`define SCC_CMD_RESET_EXT 3'd2
`define SCC_CMD_RX_FIRST 3'd4
`define SCC_CMD_RESET_TXIP 3'd5

// wr9 reset field, bits 7:6
`define SCC_WR9_CH_RESET 2'd2
`define SCC_WR9_HW_RESET 2'd3

// bit times in clk cycles for a 14.32 MHz clock
`define SCC_DIV_WIDTH 24
`define SCC_DIV_300 24'd47733
`define SCC_DIV_1200 24'd11933
`define SCC_DIV_2400 24'd5967
`define SCC_DIV_4800 24'd2983
`define SCC_DIV_9600 24'd1492
`define SCC_DIV_14400 24'd994
`define SCC_DIV_19200 24'd746
`define SCC_DIV_28800 24'd497
`define SCC_DIV_38400 24'd373
`define SCC_DIV_57600 24'd249

`endif

// File: source/scc_pkg.sv
`include "scc_consts.svh"

package scc_pkg;

	// one cpu access, sampled on the rising edge
	typedef struct packed {
		logic       cs;
		logic       we;
		logic [1:0] rs;    // [1] data/ctl, [0] side a/b
		logic [7:0] wdata;
	} scc_bus_t;

	// channel a settings seen outside the register file
	typedef struct packed {
		logic                      rx_enable; // wr3[0]
		logic [1:0]                rx_mode;   // wr1[4:3]
		logic                      tx_ie;     // wr1[1]
		logic                      ext_ie;    // wr1[0]
		logic                      tx_enable; // wr5[3]
		logic                      mie;       // wr9[3]
		logic                      vis;       // wr9[4]
		logic                      dcd_ie;    // wr15[3]
		logic [1:0]                loop_mode; // wr14[1:0]
		logic [`SCC_DIV_WIDTH-1:0] divisor;
	} scc_cfg_t;

	// single cycle strobes
	typedef struct packed {
		logic reset_ext;
		logic reset_txip;
		logic rx_first;
		logic tx_write;
		logic rx_read;
		logic chan_reset;
	} scc_cmd_t;

	typedef struct packed {
		logic       rx_ip;
		logic       tx_ip;
		logic       ext_ip;
		logic       dcd_latched;
		logic [2:0] vec_stat;
	} scc_irq_stat_t;

	typedef struct packed {
		logic       avail;
		logic [7:0] data;
	} scc_rx_stat_t;

endpackage

// File: source/scc_regs.sv
`timescale 1ns/100ps
`include "scc_consts.svh"

module scc_regs import scc_pkg::*; (
	input  logic          i_clk,
	input  logic          i_reset_hw,
	input  scc_bus_t      i_bus,
	input  scc_irq_stat_t i_stat,
	input  scc_rx_stat_t  i_rx,
	input  logic          i_tx_busy,
	input  logic          i_dcd,
	output scc_cfg_t      o_cfg,
	output scc_cmd_t      o_cmd,
	output logic [7:0]    o_tx_data,
	output logic [7:0]    o_rdata
);

	logic [3:0] ptr;       // index used by accesses
	logic [3:0] ptr_next;  // pending index, taken over once cs drops
	logic       ctl_wr;    // control write from either side
	logic       ctl_wr_a;
	logic       wr0_a;     // command write to channel a
	logic       data_wr_a;
	logic       data_rd_a;
	logic       wr9_wr;
	logic       force_rst; // wr9 hardware reset command
	logic       chan_rst;
	logic [2:0] cmd_code;
	logic [7:0] wr1;
	logic [7:0] wr2;       // shared vector
	logic [7:0] wr3;
	logic [7:0] wr5;
	logic [5:0] wr9;       // reset field is not stored
	logic [7:0] wr12;
	logic [7:0] wr13;
	logic [7:0] wr14;
	logic [7:0] wr15;
	logic [7:0] rr0;
	logic [7:0] rr1;
	logic [7:0] rr2;
	logic [7:0] rr3;
	logic [7:0] rr15;

	assign ctl_wr    = i_bus.cs & i_bus.we & ~i_bus.rs[1];
	assign ctl_wr_a  = ctl_wr & i_bus.rs[0];
	assign wr0_a     = ctl_wr_a & (ptr == `SCC_REG_WR0);
	assign data_wr_a = i_bus.cs & i_bus.we & (i_bus.rs == 2'b11);
	assign data_rd_a = i_bus.cs & ~i_bus.we & (i_bus.rs == 2'b11);
	assign cmd_code  = i_bus.wdata[5:3];

	assign wr9_wr    = ctl_wr & (ptr == `SCC_REG_WR9); // wr9 is reachable from both sides
	assign force_rst = wr9_wr & (i_bus.wdata[7:6] == `SCC_WR9_HW_RESET);
	assign chan_rst  = force_rst | (wr9_wr & (i_bus.wdata[7:6] == `SCC_WR9_CH_RESET));

	// pointer moves only between cpu cycles so read data holds during an access
	always_ff @(posedge i_clk or posedge i_reset_hw) begin
		if (i_reset_hw) begin
			ptr      <= '0;
			ptr_next <= '0;
		end else begin
			if (!i_bus.cs)
				ptr <= ptr_next;
			if (ctl_wr) begin
				if (ptr == `SCC_REG_WR0)
					ptr_next <= {cmd_code == `SCC_CMD_POINT_HIGH, i_bus.wdata[2:0]};
				else
					ptr_next <= '0; // back to wr0 after any selected write
			end
		end
	end

	always_ff @(posedge i_clk or posedge i_reset_hw) begin
		if (i_reset_hw) begin
			wr1  <= '0;
			wr2  <= '0;
			wr3  <= '0;
			wr5  <= '0;
			wr9  <= '0;
			wr12 <= '0;
			wr13 <= '0;
			wr14 <= '0;
			wr15 <= `SCC_RST_WR15;
		end else begin
			if (chan_rst) begin
				wr1  <= {2'b00, wr1[5], 2'b00, wr1[2], 2'b00};  // keeps 5 and 2
				wr5  <= {1'b0, wr5[6:5], 4'b0000, wr5[0]};
				wr14 <= force_rst ? {wr14[7:6], 6'b110000}
				                  : {wr14[7:6], 4'b1000, wr14[1:0]}; // loop bits survive
				wr15 <= `SCC_RST_WR15;
			end else if (ctl_wr_a) begin
				case (ptr)
					`SCC_REG_WR1:  wr1  <= i_bus.wdata;
					`SCC_REG_WR3:  wr3  <= i_bus.wdata;
					`SCC_REG_WR5:  wr5  <= i_bus.wdata;
					`SCC_REG_WR12: wr12 <= i_bus.wdata;
					`SCC_REG_WR13: wr13 <= i_bus.wdata;
					`SCC_REG_WR14: wr14 <= i_bus.wdata;
					`SCC_REG_WR15: wr15 <= i_bus.wdata;
					default: ; // wr4 framing fields have no effect in 8n1
				endcase
			end
			if (ctl_wr && ptr == `SCC_REG_WR2)
				wr2 <= i_bus.wdata;
			if (wr9_wr)
				wr9 <= i_bus.wdata[5:0];
		end
	end

	// strobes are registered so each access gives exactly one pulse
	always_ff @(posedge i_clk or posedge i_reset_hw) begin
		if (i_reset_hw) begin
			o_cmd <= '0;
		end else begin
			o_cmd.reset_ext  <= wr0_a & (cmd_code == `SCC_CMD_RESET_EXT);
			o_cmd.reset_txip <= wr0_a & (cmd_code == `SCC_CMD_RESET_TXIP);
			o_cmd.rx_first   <= wr0_a & (cmd_code == `SCC_CMD_RX_FIRST);
			o_cmd.tx_write   <= data_wr_a;
			o_cmd.rx_read    <= data_rd_a;
			o_cmd.chan_reset <= chan_rst;
		end
	end

	always_ff @(posedge i_clk) begin
		if (data_wr_a)
			o_tx_data <= i_bus.wdata; // picked up by the transmitter on the strobe
	end

	always_comb begin
		o_cfg.rx_enable = wr3[0];
		o_cfg.rx_mode   = wr1[4:3];
		o_cfg.tx_ie     = wr1[1];
		o_cfg.ext_ie    = wr1[0];
		o_cfg.tx_enable = wr5[3];
		o_cfg.mie       = wr9[3];
		o_cfg.vis       = wr9[4];
		o_cfg.dcd_ie    = wr15[3];
		o_cfg.loop_mode = wr14[1:0];
		// time constant to bit time
		case ({wr13, wr12})
			16'd380: o_cfg.divisor = `SCC_DIV_300;
			16'd94:  o_cfg.divisor = `SCC_DIV_1200;
			16'd46:  o_cfg.divisor = `SCC_DIV_2400;
			16'd22:  o_cfg.divisor = `SCC_DIV_4800;
			16'd10:  o_cfg.divisor = `SCC_DIV_9600;
			16'd6:   o_cfg.divisor = `SCC_DIV_14400;
			16'd4:   o_cfg.divisor = `SCC_DIV_19200;
			16'd2:   o_cfg.divisor = `SCC_DIV_28800;
			16'd1:   o_cfg.divisor = `SCC_DIV_38400;
			16'd0:   o_cfg.divisor = `SCC_DIV_57600;
			default: o_cfg.divisor = `SCC_DIV_9600; // unknown constant falls back to 9600
		endcase
	end

	assign rr0 = {2'b00,          // break and eom
	              1'b0,           // cts
	              1'b0,           // sync/hunt
	              wr15[3] ? i_stat.dcd_latched : i_dcd,
	              ~i_tx_busy,     // tx buffer empty
	              1'b0,           // zero count
	              i_rx.avail};
	assign rr1 = {4'b0000, 3'b011, ~i_tx_busy}; // residue 011, all sent

	// status replaces bits 6:4 or 3:1 depending on vis
	assign rr2 = {wr2[7],
	              wr9[4] ? {i_stat.vec_stat[0], i_stat.vec_stat[1], i_stat.vec_stat[2]}
	                     : wr2[6:4],
	              wr9[4] ? wr2[3:1] : i_stat.vec_stat,
	              wr2[0]};
	assign rr3  = {2'b00, i_stat.rx_ip, i_stat.tx_ip, i_stat.ext_ip, 3'b000};
	assign rr15 = {wr15[7:3], 1'b0, wr15[1], 1'b0};

	always_comb begin
		o_rdata = 8'h00; // channel b reads
		if (i_bus.rs == 2'b11) begin
			o_rdata = i_rx.data;
		end else if (i_bus.rs == 2'b01) begin
			case (ptr)
				4'd0, 4'd4:  o_rdata = rr0;
				4'd1, 4'd5:  o_rdata = rr1;
				4'd2, 4'd6:  o_rdata = rr2;
				4'd3, 4'd7:  o_rdata = rr3;
				4'd8:        o_rdata = i_rx.data;
				4'd9, 4'd13: o_rdata = wr13;
				4'd11, 4'd15: o_rdata = rr15;
				4'd12:       o_rdata = wr12;
				default:     o_rdata = 8'h00; // rr10 and rr14
			endcase
		end
	end

	// cpu sees one index for the whole access
	a_ptr_stable: assert property (@(posedge i_clk) disable iff (i_reset_hw)
		i_bus.cs |=> $stable(ptr));

	a_cmd_onehot: assert property (@(posedge i_clk) disable iff (i_reset_hw)
		$onehot0(o_cmd));

endmodule

// File: source/scc_tx.sv
`timescale 1ns/100ps
`include "scc_consts.svh"

module scc_tx (
	input  logic                      i_clk,
	input  logic                      i_reset_hw,
	input  logic                      i_chan_reset,
	input  logic [`SCC_DIV_WIDTH-1:0] i_divisor,
	input  logic                      i_wr,
	input  logic [7:0]                i_data,
	output logic                      o_txd,
	output logic                      o_busy
);

	logic [9:0]                frame;   // stop, data lsb first, start
	logic [3:0]                bit_cnt; // bits sent
	logic [`SCC_DIV_WIDTH-1:0] timer;
	logic                      bit_end;

	assign bit_end = (timer >= i_divisor - 1'b1); // also covers a smaller divisor mid-frame

	always_ff @(posedge i_clk or posedge i_reset_hw) begin
		if (i_reset_hw) begin
			frame   <= '1;
			bit_cnt <= '0;
			timer   <= '0;
			o_busy  <= 1'b0;
		end else if (i_chan_reset) begin
			frame  <= '1; // abort, line back to mark
			o_busy <= 1'b0;
		end else if (!o_busy) begin
			timer   <= '0;
			bit_cnt <= '0;
			if (i_wr) begin
				frame  <= {1'b1, i_data, 1'b0};
				o_busy <= 1'b1;
			end
		end else if (bit_end) begin
			timer   <= '0;
			frame   <= {1'b1, frame[9:1]}; // marks shift in behind the frame
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == 4'd9)
				o_busy <= 1'b0;    // stop bit done
		end else begin
			timer <= timer + 1'b1;
		end
	end

	assign o_txd = frame[0];

	// idle line is mark once the stop bit has left
	a_idle_mark: assert property (@(posedge i_clk) disable iff (i_reset_hw)
		!o_busy |-> o_txd);

endmodule

// File: source/scc_rx.sv
`timescale 1ns/100ps
`include "scc_consts.svh"

module scc_rx import scc_pkg::*; (
	input  logic                      i_clk,
	input  logic                      i_reset_hw,
	input  logic                      i_chan_reset,
	input  logic [`SCC_DIV_WIDTH-1:0] i_divisor,
	input  logic                      i_rxd,
	input  logic                      i_read,
	output scc_rx_stat_t              o_rx,
	output logic                      o_wr
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START, // wait half a bit and recheck
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t                 state;
	logic [1:0]                sync;     // line synchronizer
	logic                      rxd;
	logic [`SCC_DIV_WIDTH-1:0] timer;
	logic [2:0]                bit_cnt;
	logic [7:0]                shift;
	logic [7:0]                data;     // last good character
	logic                      avail;
	logic                      half_bit;
	logic                      full_bit;
	logic                      sample;
	logic                      done;

	assign rxd      = sync[1];
	assign half_bit = (timer >= (i_divisor >> 1));
	assign full_bit = (timer >= i_divisor - 1'b1);
	assign sample   = (state == RX_DATA) & full_bit;
	assign done     = (state == RX_STOP) & full_bit & rxd & ~i_chan_reset; // stop bit must be mark

	always_ff @(posedge i_clk or posedge i_reset_hw) begin
		if (i_reset_hw)
			sync <= 2'b11;
		else
			sync <= {sync[0], i_rxd};
	end

	always_ff @(posedge i_clk or posedge i_reset_hw) begin
		if (i_reset_hw) begin
			state   <= RX_IDLE;
			timer   <= '0;
			bit_cnt <= '0;
			avail   <= 1'b0;
			o_wr    <= 1'b0;
		end else begin
			o_wr  <= 1'b0;
			timer <= timer + 1'b1;
			if (i_read)
				avail <= 1'b0;
			if (i_chan_reset) begin
				state <= RX_IDLE;
				avail <= 1'b0;
			end else begin
				case (state)
					RX_IDLE: begin
						timer <= '0;
						if (!rxd)
							state <= RX_START;
					end
					RX_START: if (half_bit) begin
						timer   <= '0;
						bit_cnt <= '0;
						state   <= rxd ? RX_IDLE : RX_DATA; // glitch goes back to idle
					end
					RX_DATA: if (full_bit) begin
						timer   <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end
					default: if (full_bit) begin
						state <= RX_IDLE;
						if (rxd) begin
							avail <= 1'b1; // overwrites an unread character
							o_wr  <= 1'b1;
						end
					end
				endcase
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (sample)
			shift <= {rxd, shift[7:1]}; // lsb first
		if (done)
			data <= shift;
	end

	assign o_rx.avail = avail;
	assign o_rx.data  = data;

endmodule

// File: source/scc_irq.sv
`timescale 1ns/100ps

module scc_irq import scc_pkg::*; (
	input  logic          i_clk,
	input  logic          i_reset_hw,
	input  scc_cfg_t      i_cfg,
	input  scc_cmd_t      i_cmd,
	input  logic          i_rx_avail,
	input  logic          i_tx_busy,
	input  logic          i_dcd,
	output scc_irq_stat_t o_stat,
	output logic          o_irq_n
);

	logic rx_first;   // armed for interrupt on first character
	logic rx_ip;
	logic busy_q;
	logic tx_ip;
	logic ext_ip;
	logic latch_open;
	logic dcd_latch;  // follows dcd while open, holds once closed
	logic dcd_change;

	// mode 01 first char, mode 10 every char
	assign rx_ip = i_cfg.rx_enable & i_rx_avail &
	               (((i_cfg.rx_mode == 2'b01) & rx_first) | (i_cfg.rx_mode == 2'b10));

	always_ff @(posedge i_clk or posedge i_reset_hw) begin
		if (i_reset_hw)
			rx_first <= 1'b1;
		else if (i_cmd.chan_reset || i_cmd.rx_first)
			rx_first <= 1'b1;
		else if (i_cmd.rx_read)
			rx_first <= 1'b0;
	end

	// tx pending on busy falling edge
	always_ff @(posedge i_clk or posedge i_reset_hw) begin
		if (i_reset_hw) begin
			busy_q <= 1'b0;
			tx_ip  <= 1'b0;
		end else begin
			busy_q <= i_tx_busy;
			if (i_cmd.chan_reset || i_cmd.reset_txip || i_cmd.tx_write || !i_cfg.tx_enable)
				tx_ip <= 1'b0; // a new data write also clears it
			else if (busy_q && !i_tx_busy && i_cfg.tx_ie)
				tx_ip <= 1'b1;
		end
	end

	assign dcd_change = latch_open & i_cfg.dcd_ie & (i_dcd != dcd_latch);

	always_ff @(posedge i_clk or posedge i_reset_hw) begin
		if (i_reset_hw) begin
			latch_open <= 1'b1;
			dcd_latch  <= 1'b0;
			ext_ip     <= 1'b0;
		end else if (i_cmd.chan_reset || i_cmd.reset_ext) begin
			latch_open <= 1'b1;
			dcd_latch  <= i_dcd; // resample so a change during the closed time is dropped
			ext_ip     <= 1'b0;
		end else if (latch_open) begin
			dcd_latch <= i_dcd;
			if (dcd_change) begin
				latch_open <= 1'b0;
				if (i_cfg.ext_ie)
					ext_ip <= 1'b1;
			end
		end
	end

	assign o_stat.rx_ip       = rx_ip;
	assign o_stat.tx_ip       = tx_ip;
	assign o_stat.ext_ip      = ext_ip;
	assign o_stat.dcd_latched = dcd_latch;
	assign o_stat.vec_stat    = rx_ip  ? 3'b110 :
	                            tx_ip  ? 3'b100 :
	                            ext_ip ? 3'b101 : 3'b011;

	assign o_irq_n = ~(i_cfg.mie & (rx_ip | tx_ip | ext_ip));

	// request only with mie and a real vector behind it
	a_irq_mie: assert property (@(posedge i_clk) disable iff (i_reset_hw)
		!o_irq_n |-> i_cfg.mie && (o_stat.vec_stat != 3'b011));

endmodule

// File: source/scc_top.sv
`timescale 1ns/100ps

module scc_top import scc_pkg::*; (
	input  logic       clk,
	input  logic       reset_hw,
	input  scc_bus_t   i_bus,
	input  logic       i_rxd,
	input  logic       i_dcd,
	output logic [7:0] o_rdata,
	output logic       o_irq_n,
	output logic       o_txd,
	output logic       o_rts
);

	scc_cfg_t      cfg;
	scc_cmd_t      cmd;
	scc_irq_stat_t stat;
	scc_rx_stat_t  rx;
	logic [7:0]    tx_data;    // cpu byte for the transmitter
	logic          tx_busy;
	logic          tx_line;    // transmitter output ahead of the pin
	logic          rx_line;    // receiver input after loop select
	logic          rx_wr;
	logic          local_loop;
	logic          echo;
	logic          tx_wr;
	logic [7:0]    tx_din;

	assign local_loop = cfg.loop_mode[1];         // 10 and 11
	assign echo       = (cfg.loop_mode == 2'b01);

	assign rx_line = local_loop ? tx_line : i_rxd;
	assign tx_wr   = echo ? rx_wr : cmd.tx_write;  // echo resends what came in
	assign tx_din  = echo ? rx.data : tx_data;
	assign o_txd   = local_loop ? 1'b1 : tx_line;  // pin idles while looped
	assign o_rts   = rx.avail;

	scc_regs u_regs (
		.i_clk      (clk),
		.i_reset_hw (reset_hw),
		.i_bus      (i_bus),
		.i_stat     (stat),
		.i_rx       (rx),
		.i_tx_busy  (tx_busy),
		.i_dcd      (i_dcd),
		.o_cfg      (cfg),
		.o_cmd      (cmd),
		.o_tx_data  (tx_data),
		.o_rdata    (o_rdata)
	);

	scc_tx u_tx (
		.i_clk        (clk),
		.i_reset_hw   (reset_hw),
		.i_chan_reset (cmd.chan_reset),
		.i_divisor    (cfg.divisor),
		.i_wr         (tx_wr),
		.i_data       (tx_din),
		.o_txd        (tx_line),
		.o_busy       (tx_busy)
	);

	scc_rx u_rx (
		.i_clk        (clk),
		.i_reset_hw   (reset_hw),
		.i_chan_reset (cmd.chan_reset),
		.i_divisor    (cfg.divisor),
		.i_rxd        (rx_line),
		.i_read       (cmd.rx_read),
		.o_rx         (rx),
		.o_wr         (rx_wr)
	);

	scc_irq u_irq (
		.i_clk      (clk),
		.i_reset_hw (reset_hw),
		.i_cfg      (cfg),
		.i_cmd      (cmd),
		.i_rx_avail (rx.avail),
		.i_tx_busy  (tx_busy),
		.i_dcd      (i_dcd),
		.o_stat     (stat),
		.o_irq_n    (o_irq_n)
	);

endmodule

// File: verification/scc_tb.sv
`timescale 1ns/100ps
`include "scc_consts.svh"

module scc_tb import scc_pkg::*; ();

	localparam int BIT_CYCLES = `SCC_DIV_57600; // time constant 0
	localparam int FRAME_WAIT = 12 * BIT_CYCLES;

	logic       clk = 1'b0;
	logic       reset_hw;
	scc_bus_t   bus;
	logic       rxd;
	logic       dcd;
	logic [7:0] rdata;
	logic       irq_n;
	logic       txd;
	logic       rts;

	// model of the channel as the cpu should see it
	logic [7:0] shadow [0:15];
	logic       exp_avail;
	logic [7:0] exp_rx_data;
	logic       exp_tx_ip;
	logic       exp_ext_ip;
	logic       exp_dcd_latch;
	logic       latch_open;
	logic       watch_idle_txd; // pin must stay at mark while looped
	int         n_errors;
	int         n_checks;
	integer     seed = 32'hd09d_8b00;

	always #4 clk = ~clk;

	scc_top DUT (
		.clk      (clk),
		.reset_hw (reset_hw),
		.i_bus    (bus),
		.i_rxd    (rxd),
		.i_dcd    (dcd),
		.o_rdata  (rdata),
		.o_irq_n  (irq_n),
		.o_txd    (txd),
		.o_rts    (rts)
	);

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] want);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("FAILED at %0t: %s = %b, expected %b", $time, name, got, want);
		end
	endtask

	task automatic check_stat(input string name, input scc_irq_stat_t got,
	                          input scc_irq_stat_t want);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("FAILED at %0t: %s = %b, expected %b", $time, name, got, want);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		n_errors++;
		$display("timeout at %0t: %s", $time, what);
		$display("checks %0d, errors %0d", n_checks, n_errors);
		$display("*** FAILED ***");
		$finish;
	endtask

	// mode 10 only, first-char mode is not exercised
	function automatic logic rx_pending();
		rx_pending = shadow[3][0] & exp_avail & (shadow[1][4:3] == 2'b10);
	endfunction

	function automatic logic [7:0] scc_ref_read(input logic [3:0] idx);
		logic [2:0] vec;
		logic       rx_ip;
		rx_ip = rx_pending();
		vec   = rx_ip ? 3'b110 : exp_tx_ip ? 3'b100 : exp_ext_ip ? 3'b101 : 3'b011;
		case (idx)
			4'd0, 4'd4:   scc_ref_read = {4'b0000, shadow[15][3] ? exp_dcd_latch : dcd,
			                              2'b10, exp_avail}; // tx idle when read
			4'd1, 4'd5:   scc_ref_read = 8'h07;             // all sent, residue 011
			4'd2, 4'd6:   scc_ref_read = shadow[9][4] ?
			                  {shadow[2][7], vec[0], vec[1], vec[2], shadow[2][3:0]} :
			                  {shadow[2][7:4], vec, shadow[2][0]};
			4'd3, 4'd7:   scc_ref_read = {2'b00, rx_ip, exp_tx_ip, exp_ext_ip, 3'b000};
			4'd8:         scc_ref_read = exp_rx_data;
			4'd9, 4'd13:  scc_ref_read = shadow[13];
			4'd11, 4'd15: scc_ref_read = {shadow[15][7:3], 1'b0, shadow[15][1], 1'b0};
			4'd12:        scc_ref_read = shadow[12];
			default:      scc_ref_read = 8'h00;
		endcase
	endfunction

	// one access, cs for one cycle then two idle cycles
	task automatic bus_cycle(input logic we, input logic [1:0] rs, input logic [7:0] wdata,
	                         output logic [7:0] rd);
		@(posedge clk);
		bus <= {1'b1, we, rs, wdata};
		@(negedge clk);
		rd = rdata;
		@(posedge clk);
		bus <= '0;
		repeat (2) @(posedge clk);
	endtask

	task automatic ctl_write(input logic [7:0] data);
		logic [7:0] unused;
		bus_cycle(1'b1, 2'b01, data, unused); // control port, channel a
	endtask

	task automatic point_to(input logic [3:0] idx);
		ctl_write({2'b00, idx[3] ? `SCC_CMD_POINT_HIGH : 3'd0, idx[2:0]});
	endtask

	task automatic update_shadow(input logic [3:0] idx, input logic [7:0] data);
		if (idx == `SCC_REG_WR9) begin
			if (data[7:6] == `SCC_WR9_CH_RESET) begin
				shadow[1]     = {2'b00, shadow[1][5], 2'b00, shadow[1][2], 2'b00};
				shadow[5]     = {1'b0, shadow[5][6:5], 4'b0000, shadow[5][0]};
				shadow[14]    = {shadow[14][7:6], 4'b1000, shadow[14][1:0]};
				shadow[15]    = `SCC_RST_WR15;
				exp_avail     = 1'b0;
				exp_tx_ip     = 1'b0;
				exp_ext_ip    = 1'b0;
				latch_open    = 1'b1;
				exp_dcd_latch = dcd;
			end
			shadow[9] = {2'b00, data[5:0]}; // command field not kept
		end else begin
			shadow[idx] = data;
		end
	endtask

	task automatic write_reg(input logic [3:0] idx, input logic [7:0] data);
		point_to(idx);
		ctl_write(data);
		update_shadow(idx, data);
	endtask

	task automatic read_reg(input logic [3:0] idx, output logic [7:0] v);
		if (idx != 4'd0)
			point_to(idx);
		bus_cycle(1'b0, 2'b01, 8'h00, v);
		if (idx != 4'd0)
			ctl_write(shadow[idx]); // pointer clears only on a write, same value goes back
	endtask

	task automatic check_reg(input logic [3:0] idx, input string name);
		logic [7:0] v;
		read_reg(idx, v);
		check_byte(name, v, scc_ref_read(idx));
	endtask

	task automatic check_pending(input string name);
		logic [7:0]    v;
		scc_irq_stat_t got;
		scc_irq_stat_t want;
		read_reg(4'd3, v);
		got         = '0;
		got.rx_ip   = v[5];
		got.tx_ip   = v[4];
		got.ext_ip  = v[3];
		want        = '0;
		want.rx_ip  = rx_pending();
		want.tx_ip  = exp_tx_ip;
		want.ext_ip = exp_ext_ip;
		check_stat(name, got, want);
	endtask

	task automatic write_cmd(input logic [2:0] code);
		ctl_write({2'b00, code, 3'b000});
		if (code == `SCC_CMD_RESET_TXIP)
			exp_tx_ip = 1'b0;
		if (code == `SCC_CMD_RESET_EXT) begin
			latch_open    = 1'b1; // latch reopens on the present level
			exp_dcd_latch = dcd;
			exp_ext_ip    = 1'b0;
		end
	endtask

	task automatic data_write(input logic [7:0] data);
		logic [7:0] unused;
		bus_cycle(1'b1, 2'b11, data, unused);
		exp_tx_ip = 1'b0;
	endtask

	task automatic data_read(output logic [7:0] v);
		bus_cycle(1'b0, 2'b11, 8'h00, v);
		exp_avail = 1'b0;
	endtask

	task automatic send_rxd(input logic [7:0] b);
		logic [9:0] frame;
		int         i;
		frame = {1'b1, b, 1'b0}; // stop, data, start
		for (i = 0; i < 10; i++) begin
			@(posedge clk);
			rxd <= frame[i];
			repeat (BIT_CYCLES - 1) @(posedge clk);
		end
	endtask

	// finds the start bit, then samples each bit in its middle
	task automatic capture_txd(output logic [7:0] b);
		int n;
		int i;
		n = 0;
		@(negedge clk);
		while (txd !== 1'b0) begin
			if (n == FRAME_WAIT) begin
				stop_on_timeout("no start bit on o_txd");
			end else begin
				n++;
				@(negedge clk);
			end
		end
		repeat (BIT_CYCLES / 2) @(negedge clk);
		check_bit("o_txd start bit", txd, 1'b0);
		for (i = 0; i < 8; i++) begin
			repeat (BIT_CYCLES) @(negedge clk);
			b[i] = txd; // lsb first
		end
		repeat (BIT_CYCLES) @(negedge clk);
		check_bit("o_txd stop bit", txd, 1'b1);
	endtask

	task automatic wait_rts(input logic val);
		int n;
		n = 0;
		@(negedge clk);
		while (rts !== val) begin
			if (n == FRAME_WAIT) begin
				stop_on_timeout("o_rts did not reach the expected level");
			end else begin
				n++;
				@(negedge clk);
			end
		end
	endtask

	task automatic wait_irq_n(input logic val);
		int n;
		n = 0;
		@(negedge clk);
		while (irq_n !== val) begin
			if (n == 64) begin
				stop_on_timeout("o_irq_n did not reach the expected level");
			end else begin
				n++;
				@(negedge clk);
			end
		end
	endtask

	task automatic wait_tx_idle();
		logic [7:0] v;
		int         n;
		n = 0;
		read_reg(4'd0, v);
		while (!v[2]) begin // rr0 tx buffer empty
			if (n == FRAME_WAIT) begin
				stop_on_timeout("transmitter stayed busy");
			end else begin
				n++;
				read_reg(4'd0, v);
			end
		end
	endtask

	task automatic drive_dcd(input logic val);
		@(posedge clk);
		dcd <= val;
		if (latch_open && shadow[15][3] && val != exp_dcd_latch) begin
			latch_open    = 1'b0; // closes on the new level
			exp_dcd_latch = val;
			if (shadow[1][0])
				exp_ext_ip = 1'b1;
		end else if (latch_open) begin
			exp_dcd_latch = val;
		end
	endtask

	always @(negedge clk) begin
		if (watch_idle_txd)
			check_bit("o_txd in local loopback", txd, 1'b1);
	end

	initial begin
		logic [7:0] v;
		logic [7:0] got;
		int         i;
		bus            = '0;
		rxd            = 1'b1;
		dcd            = 1'b0;
		reset_hw       = 1'b1;
		watch_idle_txd = 1'b0;
		n_errors       = 0;
		n_checks       = 0;
		for (i = 0; i < 16; i++)
			shadow[i] = 8'h00;
		shadow[15]    = `SCC_RST_WR15;
		exp_avail     = 1'b0;
		exp_rx_data   = 8'h00;
		exp_tx_ip     = 1'b0;
		exp_ext_ip    = 1'b0;
		exp_dcd_latch = 1'b0;
		latch_open    = 1'b1;
		repeat (5) @(posedge clk);
		reset_hw <= 1'b0;
		repeat (2) @(posedge clk);

		// reset state
		check_reg(4'd15, "RR15 after reset");
		@(negedge clk);
		check_bit("o_irq_n", irq_n, 1'b1);
		check_bit("o_txd", txd, 1'b1);
		check_bit("o_rts", rts, 1'b0);

		// register readback and mirrors
		v = 8'($random(seed));
		write_reg(4'd12, v);
		v = 8'($random(seed));
		write_reg(4'd13, v);
		check_reg(4'd12, "RR12");
		check_reg(4'd13, "RR13");
		check_reg(4'd9, "RR9");
		v = 8'($random(seed));
		write_reg(4'd15, v);
		check_reg(4'd15, "RR15");
		check_reg(4'd11, "RR11");
		write_reg(4'd9, {`SCC_WR9_CH_RESET, 6'b000000});
		check_reg(4'd15, "RR15 after channel reset");
		write_reg(4'd12, 8'h00); // back to 57600
		write_reg(4'd13, 8'h00);

		// transmitter
		write_reg(4'd1, 8'h02);  // tx_ie
		write_reg(4'd5, 8'h08);  // tx_enable
		for (i = 0; i < 4; i++) begin
			v = 8'($random(seed));
			fork
				data_write(v);
				capture_txd(got);
			join
			check_byte("o_txd frame", got, v);
			wait_tx_idle();
			exp_tx_ip = 1'b1; // set at the end of the frame
			check_pending("RR3 tx pending");
			write_cmd(`SCC_CMD_RESET_TXIP);
			check_pending("RR3 after reset txip");
		end

		// receiver with interrupt on every character
		write_reg(4'd1, 8'h10);
		write_reg(4'd3, 8'h01);
		write_reg(4'd9, 8'h08);  // mie
		for (i = 0; i < 4; i++) begin
			v = 8'($random(seed));
			send_rxd(v);
			wait_rts(1'b1);
			exp_avail   = 1'b1;
			exp_rx_data = v;
			check_reg(4'd0, "RR0 char available");
			check_reg(4'd2, "RR2 rx vector");
			@(negedge clk);
			check_bit("o_irq_n with rx pending", irq_n, 1'b0);
			data_read(got);
			check_byte("rx data", got, v);
			@(negedge clk);
			check_bit("o_irq_n after data read", irq_n, 1'b1);
			check_bit("o_rts after data read", rts, 1'b0);
		end

		// local loopback, then auto-echo
		write_reg(4'd14, 8'h02);
		watch_idle_txd = 1'b1;
		v = 8'($random(seed));
		data_write(v);
		wait_rts(1'b1);
		exp_avail   = 1'b1;
		exp_rx_data = v;
		data_read(got);
		check_byte("loopback data", got, v);
		wait_tx_idle();
		watch_idle_txd = 1'b0;
		write_reg(4'd14, 8'h01);
		v = 8'($random(seed));
		fork
			send_rxd(v);
			capture_txd(got);
		join
		check_byte("echo on o_txd", got, v);
		exp_avail   = 1'b1;
		exp_rx_data = v;
		data_read(got);
		check_byte("echo rx data", got, v);
		wait_tx_idle();
		write_reg(4'd14, 8'h00);

		// dcd external/status interrupt
		write_reg(4'd1, 8'h11);  // ext_ie, rx mode kept
		drive_dcd(1'b1);
		wait_irq_n(1'b0);
		check_pending("RR3 ext pending");
		check_reg(4'd0, "RR0 dcd latched");
		drive_dcd(1'b0);
		repeat (4) @(posedge clk); // flags settle within one cycle
		check_pending("RR3 after second toggle");
		check_reg(4'd0, "RR0 dcd held");
		write_cmd(`SCC_CMD_RESET_EXT);
		check_pending("RR3 after reset ext");
		check_reg(4'd0, "RR0 after reset ext");
		@(negedge clk);
		check_bit("o_irq_n after reset ext", irq_n, 1'b1);

		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+source
source/scc_pkg.sv
source/scc_regs.sv
source/scc_tx.sv
source/scc_rx.sv
source/scc_irq.sv
source/scc_top.sv
verification/scc_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= scc_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
